/* Makefile */
VERILATOR  ?= verilator
TOP        ?= renkon_tb
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test FAILED" $(LOG); then echo "Simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "Test OK" $(LOG) || { echo "No pass message in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* files.f */
src/renkon_pkg.sv
src/renkon_count.sv
src/renkon_ctrl.sv
src/renkon_conv.sv
src/renkon_bias_act.sv
src/renkon_pool.sv
src/renkon_top.sv
tb/renkon_tb.sv

/* src/renkon_bias_act.sv */
`timescale 1ns/1ps
`default_nettype none

module renkon_bias_act
  ( input  logic              clk
  , input  logic              rst_n
  , input  logic              breg_we
  , input  renkon_pkg::data_t read_bias
  , input  renkon_pkg::data_t pixel_in
  , input  logic              bias_en
  , input  logic              relu_en
  , input  logic              out_en
  , output renkon_pkg::data_t pixel_out
  );

  renkon_pkg::data_t bias;
  renkon_pkg::data_t addend;
  renkon_pkg::acc_t  biased;
  renkon_pkg::data_t clamped;
  renkon_pkg::data_t act;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bias <= '0;
    end else if (breg_we) begin
      bias <= read_bias;
    end
  end

  assign addend = bias_en ? bias : '0;

  // The wide sum cannot overflow, so one clamp afterwards is enough
  assign biased  = renkon_pkg::acc_t'(pixel_in) + renkon_pkg::acc_t'(addend);
  assign clamped = renkon_pkg::sat_data(biased);

  always_comb begin
    act = clamped;
    if (relu_en && clamped < 0) begin
      act = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (out_en) begin
      pixel_out <= act;
    end
  end

endmodule

`default_nettype wire

/* src/renkon_conv.sv */
`timescale 1ns/1ps
`default_nettype none

module renkon_conv
  ( input  logic                          clk
  , input  logic                          rst_n
  , input  logic [renkon_pkg::N_TAPS-1:0] wreg_we
  , input  renkon_pkg::data_t             read_weight
  , input  renkon_pkg::data_t             pixel_in [renkon_pkg::N_TAPS-1:0]
  , input  renkon_pkg::qbits_t            qbits
  , input  logic                          out_en
  , output renkon_pkg::data_t             pixel_out
  );

  renkon_pkg::data_t weight [renkon_pkg::N_TAPS-1:0];
  renkon_pkg::acc_t  sum;
  renkon_pkg::acc_t  shifted;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < renkon_pkg::N_TAPS; i++) begin
        weight[i] <= '0;
      end
    end else begin
      for (int i = 0; i < renkon_pkg::N_TAPS; i++) begin
        if (wreg_we[i]) begin
          weight[i] <= read_weight;
        end
      end
    end
  end

  // Products are widened to the accumulator before the add
  always_comb begin
    sum = '0;
    for (int i = 0; i < renkon_pkg::N_TAPS; i++) begin
      sum = sum + renkon_pkg::acc_t'(pixel_in[i]) * renkon_pkg::acc_t'(weight[i]);
    end
  end

  assign shifted = sum >>> qbits;  // Sign fills from the left

  always_ff @(posedge clk) begin
    if (out_en) begin
      pixel_out <= renkon_pkg::sat_data(shifted);
    end
  end

endmodule

`default_nettype wire

/* src/renkon_count.sv */
`timescale 1ns/1ps
`default_nettype none

module renkon_count
  ( input  logic                   clk
  , input  logic                   rst_n
  , input  logic                   param_we
  , input  logic                   pixel_valid
  , input  logic                   clear
  , input  logic                   run
  , output renkon_pkg::param_idx_t param_idx
  , output logic                   param_last
  , output logic                   pool_last
  );

  renkon_pkg::param_idx_t param_cnt;
  renkon_pkg::pool_pos_t  pool_pos;
  logic                   win_acc;
  logic                   last_d1;
  logic                   last_d2;

  assign win_acc    = pixel_valid && run;  // Windows in ST_LOAD never count
  assign param_idx  = param_cnt;
  assign param_last = param_cnt == renkon_pkg::param_idx_t'(renkon_pkg::N_PARAMS - 1);
  assign pool_last  = last_d2;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      param_cnt <= '0;
    end else if (param_we) begin
      param_cnt <= param_last ? '0 : param_cnt + 1'b1;
    end
  end

  // A reload restarts the grouping so the next window opens a new group
  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      pool_pos <= '0;
    end else if (win_acc) begin
      if (pool_pos == renkon_pkg::pool_pos_t'(renkon_pkg::POOL_N - 1)) begin
        pool_pos <= '0;
      end else begin
        pool_pos <= pool_pos + 1'b1;
      end
    end
  end

  // Two stages of delay put the flag beside pool_oe at the pool stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      last_d1 <= 1'b0;
      last_d2 <= 1'b0;
    end else begin
      last_d1 <= win_acc && (pool_pos == renkon_pkg::pool_pos_t'(renkon_pkg::POOL_N - 1));
      last_d2 <= last_d1;
    end
  end

  a_param_cnt_range: assert property (@(posedge clk) disable iff (!rst_n)
    param_cnt <= renkon_pkg::param_idx_t'(renkon_pkg::N_PARAMS - 1));

endmodule

`default_nettype wire

/* src/renkon_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module renkon_ctrl
  ( input  logic                          clk
  , input  logic                          rst_n
  , input  logic                          param_we
  , input  logic                          pixel_valid
  , input  renkon_pkg::param_idx_t        param_idx
  , input  logic                          param_last
  , output logic                          run
  , output logic                          cnt_clear
  , output logic [renkon_pkg::N_TAPS-1:0] wreg_we
  , output logic                          breg_we
  , output logic                          conv_oe
  , output logic                          bias_oe
  , output logic                          pool_oe
  );

  renkon_pkg::ctrl_state_t state;
  renkon_pkg::ctrl_state_t state_nxt;

  always_comb begin
    state_nxt = state;
    case (state)
      renkon_pkg::ST_LOAD: begin
        if (param_we && param_last) begin
          state_nxt = renkon_pkg::ST_RUN;  // Bias is the last word of a load
        end
      end
      renkon_pkg::ST_RUN: begin
        if (param_we) begin
          state_nxt = renkon_pkg::ST_LOAD;
        end
      end
      default: state_nxt = renkon_pkg::ST_LOAD;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= renkon_pkg::ST_LOAD;
    end else begin
      state <= state_nxt;
    end
  end

  assign run       = state == renkon_pkg::ST_RUN;
  assign cnt_clear = run && param_we;

  // In ST_RUN the word count already sits at zero, so a reload lands on weight 0
  always_comb begin
    wreg_we = '0;
    breg_we = 1'b0;
    if (param_we) begin
      if (param_idx < renkon_pkg::param_idx_t'(renkon_pkg::N_TAPS)) begin
        wreg_we[param_idx] = 1'b1;
      end else if (param_idx == renkon_pkg::param_idx_t'(renkon_pkg::N_TAPS)) begin
        breg_we = 1'b1;
      end
    end
  end

  assign conv_oe = run && pixel_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      bias_oe <= 1'b0;
      pool_oe <= 1'b0;
    end else begin
      bias_oe <= conv_oe;  // One cycle per stage
      pool_oe <= bias_oe;
    end
  end

  a_we_onehot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0(wreg_we) && !(breg_we && |wreg_we));

  // Writing the bias always completes a load
  a_bias_enters_run: assert property (@(posedge clk) disable iff (!rst_n)
    breg_we |=> run);

endmodule

`default_nettype wire

/* src/renkon_pkg.sv */
`default_nettype none

package renkon_pkg;

  localparam int DWIDTH    = 16;
  localparam int DWIDTHLOG = 4;
  localparam int CONV_MAX  = 3;
  localparam int N_TAPS    = CONV_MAX * CONV_MAX;
  localparam int N_PARAMS  = N_TAPS + 1;      // Nine weights, then the bias
  localparam int ACC_WIDTH = 2 * DWIDTH + 4;  // Guard bits cover the nine-term sum
  localparam int POOL_N    = 4;
  localparam int POOL_POS_W = $clog2(POOL_N);

  typedef logic signed [DWIDTH-1:0]    data_t;
  typedef logic signed [ACC_WIDTH-1:0] acc_t;
  typedef logic [DWIDTHLOG-1:0]        qbits_t;
  typedef logic [3:0]                  param_idx_t;
  typedef logic [POOL_POS_W-1:0]       pool_pos_t;

  typedef enum logic {
    ST_LOAD,
    ST_RUN
  } ctrl_state_t;

  localparam data_t DATA_MAX = data_t'({1'b0, {(DWIDTH-1){1'b1}}});
  localparam data_t DATA_MIN = data_t'({1'b1, {(DWIDTH-1){1'b0}}});

  // Clamp a wide signed value into the range of a data word
  function automatic data_t sat_data(input acc_t v);
    if (v > acc_t'(DATA_MAX)) begin
      return DATA_MAX;
    end
    if (v < acc_t'(DATA_MIN)) begin
      return DATA_MIN;
    end
    return data_t'(v);
  endfunction

endpackage

`default_nettype wire

/* src/renkon_pool.sv */
`timescale 1ns/1ps
`default_nettype none

module renkon_pool
  ( input  logic              clk
  , input  logic              rst_n
  , input  renkon_pkg::data_t pixel_in
  , input  logic              pool_en
  , input  logic              pool_last
  , input  logic              out_en
  , output renkon_pkg::data_t pixel_out
  , output logic              out_valid
  );

  renkon_pkg::data_t run_max;
  renkon_pkg::data_t cand;
  logic              first;  // Next window opens a group

  assign cand = (first || pixel_in > run_max) ? pixel_in : run_max;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      first     <= 1'b1;
    end else begin
      out_valid <= out_en && (!pool_en || pool_last);
      if (!pool_en) begin
        first <= 1'b1;
      end else if (out_en) begin
        first <= pool_last;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (out_en) begin
      run_max <= cand;
      if (!pool_en) begin
        pixel_out <= pixel_in;
      end else if (pool_last) begin
        pixel_out <= cand;
      end
    end
  end

  // A group spans four windows, so two results can never be adjacent
  a_pool_spacing: assert property (@(posedge clk) disable iff (!rst_n)
    (out_valid && pool_en) |=> !out_valid);

endmodule

`default_nettype wire

/* src/renkon_top.sv */
`timescale 1ns/1ps
`default_nettype none

module renkon_top
  ( input  logic               clk
  , input  logic               rst_n
  , input  logic               param_we
  , input  renkon_pkg::data_t  net_rdata
  , input  logic               pixel_valid
  , input  renkon_pkg::data_t  pixel [renkon_pkg::N_TAPS-1:0]
  , input  renkon_pkg::qbits_t qbits
  , input  logic               bias_en
  , input  logic               relu_en
  , input  logic               pool_en
  , output renkon_pkg::data_t  result
  , output logic               result_valid
  );

  renkon_pkg::param_idx_t          param_idx;
  logic                            param_last;
  logic                            pool_last;
  logic                            run;
  logic                            cnt_clear;
  logic [renkon_pkg::N_TAPS-1:0]   wreg_we;
  logic                            breg_we;
  logic                            conv_oe;
  logic                            bias_oe;
  logic                            pool_oe;
  renkon_pkg::data_t               fmap;
  renkon_pkg::data_t               amap;

  renkon_count u_count (
    .clk         (clk),
    .rst_n       (rst_n),
    .param_we    (param_we),
    .pixel_valid (pixel_valid),
    .clear       (cnt_clear),
    .run         (run),
    .param_idx   (param_idx),
    .param_last  (param_last),
    .pool_last   (pool_last)
  );

  renkon_ctrl u_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .param_we    (param_we),
    .pixel_valid (pixel_valid),
    .param_idx   (param_idx),
    .param_last  (param_last),
    .run         (run),
    .cnt_clear   (cnt_clear),
    .wreg_we     (wreg_we),
    .breg_we     (breg_we),
    .conv_oe     (conv_oe),
    .bias_oe     (bias_oe),
    .pool_oe     (pool_oe)
  );

  // Weights and bias share the parameter data port
  renkon_conv u_conv (
    .clk         (clk),
    .rst_n       (rst_n),
    .wreg_we     (wreg_we),
    .read_weight (net_rdata),
    .pixel_in    (pixel),
    .qbits       (qbits),
    .out_en      (conv_oe),
    .pixel_out   (fmap)
  );

  renkon_bias_act u_bias_act (
    .clk       (clk),
    .rst_n     (rst_n),
    .breg_we   (breg_we),
    .read_bias (net_rdata),
    .pixel_in  (fmap),
    .bias_en   (bias_en),
    .relu_en   (relu_en),
    .out_en    (bias_oe),
    .pixel_out (amap)
  );

  renkon_pool u_pool (
    .clk       (clk),
    .rst_n     (rst_n),
    .pixel_in  (amap),
    .pool_en   (pool_en),
    .pool_last (pool_last),
    .out_en    (pool_oe),
    .pixel_out (result),
    .out_valid (result_valid)
  );

endmodule

`default_nettype wire

/* tb/renkon_stim.txt */
# T name | C qbits bias_en relu_en pool_en | P w0..w8 bias (hex)
# W gap(0 back-to-back, 1 random idle) pix0..pix8 (hex) has_exp exp (hex)
T plain_conv
C 0 0 0 0
P 0001 0002 0003 0004 0005 0006 0007 0008 0009 0064
W 0 0001 0001 0001 0001 0001 0001 0001 0001 0001 1 002d
W 0 0001 0000 0000 0000 0000 0000 0000 0000 ffff 1 fff8
W 0 000a 0000 0000 0000 0000 0000 0000 0000 0000 1 000a
T quantize
C 2 0 0 0
W 1 0001 0001 0001 0001 0001 0001 0001 0001 0001 1 000b
W 1 0001 0000 0000 0000 0000 0000 0000 0000 ffff 1 fffe
W 1 ffff ffff ffff ffff ffff ffff ffff ffff ffff 1 fff4
W 1 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 1 7fff
W 1 8000 8000 8000 8000 8000 8000 8000 8000 8000 1 8000
T bias
C 0 1 0 0
W 1 0001 0001 0001 0001 0001 0001 0001 0001 0001 1 0091
W 1 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 7fff 1 7fff
W 1 8000 8000 8000 8000 8000 8000 8000 8000 8000 1 8064
C 0 0 0 0
W 1 0001 0001 0001 0001 0001 0001 0001 0001 0001 1 002d
T relu
C 0 0 1 0
W 1 0001 0001 0001 0001 0001 0001 0001 0001 0001 1 002d
W 1 ffff ffff ffff ffff ffff ffff ffff ffff ffff 1 0000
W 1 0001 0000 0000 0000 0000 0000 0000 0000 ffff 1 0000
T max_pool
C 0 0 0 1
P 0001 0002 0003 0004 0005 0006 0007 0008 0009 0064
W 1 0001 0001 0001 0001 0001 0001 0001 0001 0001 0 0000
W 1 0001 0000 0000 0000 0000 0000 0000 0000 ffff 0 0000
W 1 000a 0000 0000 0000 0000 0000 0000 0000 0000 0 0000
W 1 0014 0000 0000 0000 0000 0000 0000 0000 0000 1 002d
W 1 ffff ffff ffff ffff ffff ffff ffff ffff ffff 0 0000
W 1 0001 0000 0000 0000 0000 0000 0000 0000 ffff 0 0000
W 1 0000 0000 0000 0000 0000 0000 0000 0000 0000 0 0000
W 1 0002 0000 0000 0000 0000 0000 0000 0000 0000 1 0002
T reload
W 1 0001 0000 0000 0000 0000 0000 0000 0000 ffff 0 0000
W 1 ffff ffff ffff ffff ffff ffff ffff ffff ffff 0 0000
P 0002 0002 0002 0002 0002 0002 0002 0002 0002 0005
C 0 1 0 1
W 0 0001 0001 0001 0001 0001 0001 0001 0001 0001 0 0000
W 0 0002 0002 0002 0002 0002 0002 0002 0002 0002 0 0000
W 0 0001 0000 0000 0000 0000 0000 0000 0000 0000 0 0000
W 0 ffff ffff ffff ffff ffff ffff ffff ffff ffff 1 0029

/* tb/renkon_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module renkon_tb;

  localparam string STIM_FILE = "tb/renkon_stim.txt";

  logic               clk;
  logic               rst_n;
  logic               param_we;
  renkon_pkg::data_t  net_rdata;
  logic               pixel_valid;
  renkon_pkg::data_t  pixel [renkon_pkg::N_TAPS-1:0];
  renkon_pkg::qbits_t qbits;
  logic               bias_en;
  logic               relu_en;
  logic               pool_en;
  renkon_pkg::data_t  result;
  logic               result_valid;

  renkon_pkg::data_t  exp_q [$];
  int                 due_q [$];
  renkon_pkg::data_t  pix_rd [renkon_pkg::N_TAPS-1:0];
  renkon_pkg::data_t  prm_rd [renkon_pkg::N_PARAMS-1:0];
  string              recs [$];
  int                 cycles = 0;
  int                 cycle_limit = 0;
  int                 err_cnt = 0;
  int                 check_cnt = 0;
  int                 out_cnt = 0;
  int                 exp_cnt = 0;
  int                 test_cnt = 0;
  int                 fail_cnt = 0;

  renkon_top u_renkon_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .param_we     (param_we),
    .net_rdata    (net_rdata),
    .pixel_valid  (pixel_valid),
    .pixel        (pixel),
    .qbits        (qbits),
    .bias_en      (bias_en),
    .relu_en      (relu_en),
    .pool_en      (pool_en),
    .result       (result),
    .result_valid (result_valid)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycle_limit != 0 && cycles > cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("Test FAILED");
      $finish;
    end
  end

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (rst_n && result_valid) begin
      out_cnt++;
      if (exp_q.size() > 0) begin
        check_data(result, exp_q.pop_front());
        check_timing(cycles, due_q.pop_front());
      end
    end
  end

  task automatic step();
    @(posedge clk);
    #1;
  endtask

  task automatic check_data(input renkon_pkg::data_t got, input renkon_pkg::data_t want);
    check_cnt++;
    if (got !== want) begin
      $display("** Error: result = 0x%h, expected 0x%h", got, want);
      err_cnt++;
    end
  endtask

  task automatic check_timing(input int got, input int want);
    check_cnt++;
    if (got != want) begin
      $display("Result came out in cycle %0d but was due in cycle %0d", got, want);
      err_cnt++;
    end
  endtask

  task automatic check_count(input int got, input int want);
    check_cnt++;
    if (got < want) begin
      $display("Missing output: %0d results expected, only %0d came out", want, got);
      err_cnt++;
    end else if (got > want) begin
      $display("Extra output: %0d results expected, but %0d came out", want, got);
      err_cnt++;
    end
  endtask

  task automatic bad_record(input string rec);
    $display("Malformed stimulus record: %s", rec);
    err_cnt++;
  endtask

  // Partial pool groups leave no expected value behind, hence the idle tail
  task automatic drain();
    int waited;
    waited = 0;
    while (exp_q.size() != 0 && waited < 6) begin
      step();
      waited++;
    end
    exp_q.delete();
    due_q.delete();
    repeat (4) step();
  endtask

  task automatic load_params();
    for (int i = 0; i < renkon_pkg::N_PARAMS; i++) begin
      net_rdata = prm_rd[i];
      param_we  = 1'b1;
      step();
    end
    param_we = 1'b0;
  endtask

  task automatic send_window(input bit random_gap, input bit has_exp,
                             input renkon_pkg::data_t want);
    int gap;
    gap         = random_gap ? int'($urandom % 3) : 0;
    pixel       = pix_rd;
    pixel_valid = 1'b1;
    if (has_exp) begin
      exp_q.push_back(want);
      due_q.push_back(cycles + 3);  // Result shows three cycles after the strobe
      exp_cnt++;
    end
    step();
    pixel_valid = 1'b0;
    repeat (gap) step();
  endtask

  task automatic finish_test(input string name, input int err_start);
    drain();
    check_count(out_cnt, exp_cnt);
    test_cnt++;
    if (err_cnt == err_start) begin
      $display("%-12s passed, %0d results", name, out_cnt);
    end else begin
      $display("%-12s failed, %0d errors", name, err_cnt - err_start);
      fail_cnt++;
    end
    out_cnt = 0;
    exp_cnt = 0;
  endtask

  task automatic read_stim();
    int    fd;
    string line;
    string kind;
    fd = $fopen(STIM_FILE, "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 && $sscanf(line, "%s", kind) == 1 && kind[0] != "#") begin
          recs.push_back(line);
          cycle_limit += (kind == "P") ? 20 : 10;  // Worst case per record, drains included
        end
      end
      $fclose(fd);
    end
    cycle_limit += 100;
  endtask

  task automatic run_records();
    string             kind;
    string             name;
    int                rc;
    int                gap_mode;
    int                has_exp;
    int                err_start;
    int                cfg [4];
    renkon_pkg::data_t want;
    name      = "";
    err_start = 0;
    foreach (recs[r]) begin
      rc = $sscanf(recs[r], "%s", kind);
      if (kind == "T") begin
        if (name != "") begin
          finish_test(name, err_start);
        end
        rc = $sscanf(recs[r], "%s %s", kind, name);
        err_start = err_cnt;
      end else if (kind == "C") begin
        rc = $sscanf(recs[r], "%s %d %d %d %d", kind, cfg[0], cfg[1], cfg[2], cfg[3]);
        if (rc != 5) bad_record(recs[r]);
        drain();  // Configuration only changes with the pipeline empty
        qbits   = renkon_pkg::qbits_t'(cfg[0]);
        bias_en = cfg[1] != 0;
        relu_en = cfg[2] != 0;
        pool_en = cfg[3] != 0;
      end else if (kind == "P") begin
        rc = $sscanf(recs[r], "%s %h %h %h %h %h %h %h %h %h %h", kind,
                     prm_rd[0], prm_rd[1], prm_rd[2], prm_rd[3], prm_rd[4],
                     prm_rd[5], prm_rd[6], prm_rd[7], prm_rd[8], prm_rd[9]);
        if (rc != 11) bad_record(recs[r]);
        drain();
        load_params();
      end else if (kind == "W") begin
        rc = $sscanf(recs[r], "%s %d %h %h %h %h %h %h %h %h %h %d %h", kind, gap_mode,
                     pix_rd[0], pix_rd[1], pix_rd[2], pix_rd[3], pix_rd[4],
                     pix_rd[5], pix_rd[6], pix_rd[7], pix_rd[8], has_exp, want);
        if (rc != 13) bad_record(recs[r]);
        send_window(gap_mode != 0, has_exp != 0, want);
      end else begin
        bad_record(recs[r]);
      end
    end
    if (name != "") begin
      finish_test(name, err_start);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    param_we    = 1'b0;
    net_rdata   = '0;
    pixel_valid = 1'b0;
    qbits       = '0;
    bias_en     = 1'b0;
    relu_en     = 1'b0;
    pool_en     = 1'b0;
    for (int i = 0; i < renkon_pkg::N_TAPS; i++) begin
      pixel[i] = '0;
    end
    void'($urandom(1));
    read_stim();
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    if (recs.size() == 0) begin
      $display("No records could be read from %s", STIM_FILE);
      $display("Test FAILED");
      $finish;
    end else begin
      run_records();
      $display("%0d tests, %0d failed; %0d checks, %0d errors",
               test_cnt, fail_cnt, check_cnt, err_cnt);
      if (err_cnt == 0) begin
        $display("Test OK");
      end else begin
        $display("Test FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire
